// File: hw/spi_pkg.sv
/* SPI multi-channel master types */

package spi_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int DATA_W = 8;
    localparam int CHAN_W = 2;
    // SCLK half period is div+1 clocks
    localparam int DIV_W  = 4;

    // ------------------------------
    // Command word
    // ------------------------------
    typedef enum logic {
        OP_XFER = 1'b0,
        OP_CFG  = 1'b1
    } spi_op_e;

    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        logic [DATA_W-1:0] tx_data;
    } spi_xfer_s;

    // Padding keeps div in the low bits, chan on top in both forms
    typedef struct packed {
        logic [CHAN_W-1:0]       chan;
        logic [DATA_W-DIV_W-1:0] rsvd;
        logic [DIV_W-1:0]        div;
    } spi_cfg_s;

    typedef union packed {
        spi_xfer_s xfer;
        spi_cfg_s  cfg;
    } spi_payload_u;

    typedef struct packed {
        spi_op_e      op;
        spi_payload_u payload;
    } spi_cmd_s;

    // Collector output
    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        logic [DATA_W-1:0] rx_data;
    } spi_result_s;

endpackage

// File: hw/spi_cmd_dispatch.sv
/* SPI command dispatcher */

`timescale 1ns/1ps

module spi_cmd_dispatch
    import spi_pkg::*;
#(
    parameter int NUM_CHAN = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  spi_cmd_s            cmd,
    input  logic                cmd_valid,
    input  logic [NUM_CHAN-1:0] busy,
    output logic [NUM_CHAN-1:0] start,
    output logic [NUM_CHAN-1:0] div_wr,
    output logic [DATA_W-1:0]   tx_data,
    output logic [DIV_W-1:0]    div_data,
    output logic                cmd_reject
);

    logic [CHAN_W-1:0]   chan;
    logic                chan_ok;
    logic [NUM_CHAN-1:0] occupied;
    logic                accept;

    // Chan sits in the same bits in both payload forms
    assign chan = cmd.payload.xfer.chan;

    assign chan_ok = int'(chan) < NUM_CHAN;

    // Start from last cycle covers the gap before busy rises
    assign occupied = busy | start;
    assign accept   = chan_ok && !occupied[chan];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start      <= '0;
            div_wr     <= '0;
            cmd_reject <= 1'b0;
        end else begin
            start      <= '0;
            div_wr     <= '0;
            cmd_reject <= 1'b0;
            if (cmd_valid) begin
                if (!accept) begin
                    cmd_reject <= 1'b1;
                end else if (cmd.op == OP_XFER) begin
                    start[chan] <= 1'b1;
                end else begin
                    div_wr[chan] <= 1'b1;
                end
            end
        end
    end

    // Shared data, qualified by the strobes
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            tx_data  <= cmd.payload.xfer.tx_data;
            div_data <= cmd.payload.cfg.div;
        end
    end

endmodule

// File: hw/spi_channel_engine.sv
/* SPI master channel engine */

`timescale 1ns/1ps

module spi_channel_engine
    import spi_pkg::*;
#(
    parameter logic [DIV_W-1:0] DEFAULT_DIV = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [DATA_W-1:0] tx_data,
    input  logic              div_wr,
    input  logic [DIV_W-1:0]  div_data,
    input  logic              miso,
    output logic              busy,
    output logic              sclk,
    output logic              cs_n,
    output logic              mosi,
    output logic              done,
    output logic [DATA_W-1:0] rx_data
);

    localparam int CNT_W = $clog2(DATA_W) + 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT,
        ST_FINISH
    } state_e;

    state_e            state;
    logic [DIV_W-1:0]  div_reg;
    logic [DIV_W-1:0]  div_cnt;
    logic [CNT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0] shreg;
    logic              tick;

    // SCLK edge due this cycle
    assign tick = (div_cnt == '0);

    // Divider only changes between transfers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_reg <= DEFAULT_DIV;
        end else if (div_wr && state == ST_IDLE) begin
            div_reg <= div_data;
        end
    end

    // ------------------------------
    // Transfer FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            busy    <= 1'b0;
            sclk    <= 1'b0;
            cs_n    <= 1'b1;
            mosi    <= 1'b0;
            done    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    cs_n    <= 1'b0;
                    mosi    <= shreg[DATA_W-1];
                    div_cnt <= div_reg;
                    bit_cnt <= CNT_W'(DATA_W);
                    state   <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (tick) begin
                        div_cnt <= div_reg;
                        sclk    <= ~sclk;
                        if (!sclk) begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end else if (bit_cnt == '0) begin
                            // Last falling edge, no more bits to drive
                            state <= ST_FINISH;
                        end else begin
                            mosi <= shreg[DATA_W-1];
                        end
                    end else begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                end
                ST_FINISH: begin
                    cs_n  <= 1'b1;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    mosi  <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Shift register, MISO enters on rising SCLK
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            shreg <= tx_data;
        end else if (state == ST_SHIFT && tick && !sclk) begin
            shreg <= {shreg[DATA_W-2:0], miso};
        end
        if (state == ST_FINISH) begin
            rx_data <= shreg;
        end
    end

endmodule

// File: hw/spi_result_collect.sv
/* SPI result collector */

`timescale 1ns/1ps

module spi_result_collect
    import spi_pkg::*;
#(
    parameter int NUM_CHAN = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_CHAN-1:0] done,
    input  logic [DATA_W-1:0]   rx_data [NUM_CHAN],
    output spi_result_s         result,
    output logic                result_valid
);

    logic [NUM_CHAN-1:0] pend;
    logic [NUM_CHAN-1:0] grant;
    logic [DATA_W-1:0]   hold [NUM_CHAN];
    logic [CHAN_W-1:0]   pick;

    // ------------------------------
    // Fixed priority, lowest first
    // ------------------------------
    assign grant = pend & (~pend + NUM_CHAN'(1));

    always_comb begin
        pick = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (grant[i]) begin
                pick = CHAN_W'(i);
            end
        end
    end

    assign result_valid = |pend;
    assign result       = '{chan: pick, rx_data: hold[pick]};

    // Granted flag drops at the edge ending its output cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~grant) | done;
        end
    end

    // Received bytes wait here until picked
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (done[i]) begin
                hold[i] <= rx_data[i];
            end
        end
    end

endmodule

// File: hw/spi_multi_master.sv
/* Four-channel SPI master */

`timescale 1ns/1ps

module spi_multi_master
    import spi_pkg::*;
#(
    parameter int               NUM_CHAN    = 4,
    parameter logic [DIV_W-1:0] DEFAULT_DIV = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  spi_cmd_s            cmd,
    input  logic                cmd_valid,
    output logic                cmd_reject,
    output spi_result_s         result,
    output logic                result_valid,
    output logic [NUM_CHAN-1:0] busy,
    output logic [NUM_CHAN-1:0] sclk,
    output logic [NUM_CHAN-1:0] cs_n,
    output logic [NUM_CHAN-1:0] mosi,
    input  logic [NUM_CHAN-1:0] miso
);

    logic [NUM_CHAN-1:0] start;
    logic [NUM_CHAN-1:0] div_wr;
    logic [DATA_W-1:0]   tx_data;
    logic [DIV_W-1:0]    div_data;
    logic [NUM_CHAN-1:0] done;
    logic [DATA_W-1:0]   rx_data [NUM_CHAN];

    spi_cmd_dispatch #(
        .NUM_CHAN (NUM_CHAN)
    ) u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .busy       (busy),
        .start      (start),
        .div_wr     (div_wr),
        .tx_data    (tx_data),
        .div_data   (div_data),
        .cmd_reject (cmd_reject)
    );

    // One engine per channel
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        spi_channel_engine #(
            .DEFAULT_DIV (DEFAULT_DIV)
        ) u_engine (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start[i]),
            .tx_data  (tx_data),
            .div_wr   (div_wr[i]),
            .div_data (div_data),
            .miso     (miso[i]),
            .busy     (busy[i]),
            .sclk     (sclk[i]),
            .cs_n     (cs_n[i]),
            .mosi     (mosi[i]),
            .done     (done[i]),
            .rx_data  (rx_data[i])
        );
    end

    spi_result_collect #(
        .NUM_CHAN (NUM_CHAN)
    ) u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .done         (done),
        .rx_data      (rx_data),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: testbench/spi_multi_master_properties.sv
/* SPI master protocol properties */

`timescale 1ns/1ps

module spi_multi_master_properties
    import spi_pkg::*;
#(
    parameter int NUM_CHAN = 4
) (
    input logic                clk,
    input logic                rst_n,
    input logic                cmd_valid,
    input logic                cmd_reject,
    input spi_result_s         result,
    input logic                result_valid,
    input logic [NUM_CHAN-1:0] busy,
    input logic [NUM_CHAN-1:0] sclk,
    input logic [NUM_CHAN-1:0] cs_n,
    input logic [NUM_CHAN-1:0] done
);

    // Chip select only while a transfer runs
    a_cs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (~cs_n & ~busy) == '0)
        else $error("cs_n low on a channel that is not busy");

    a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (cs_n & sclk) == '0)
        else $error("sclk high while cs_n is high");

    a_reject_cause: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_reject |-> $past(cmd_valid))
        else $error("cmd_reject without a command in the previous cycle");

    // Same channel twice in a row needs a second completion
    a_result_repeat: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && $past(result_valid) && result.chan == $past(result.chan))
        |-> $past(done[result.chan]))
        else $error("result repeated for a channel that completed once");

endmodule

bind spi_multi_master spi_multi_master_properties #(
    .NUM_CHAN (NUM_CHAN)
) u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_reject   (cmd_reject),
    .result       (result),
    .result_valid (result_valid),
    .busy         (busy),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .done         (done)
);

// File: testbench/tb_spi_multi_master.sv
/* SPI multi-master testbench */

`timescale 1ns/1ps

module tb_spi_multi_master
    import spi_pkg::*;
();

    // Three channels leave chan 3 free for the out-of-range case
    localparam int               NUM_CHAN     = 3;
    localparam logic [DIV_W-1:0] DEFAULT_DIV  = 1;
    localparam int               NUM_ENT      = 14;
    localparam int               CLK_PERIOD   = 8;
    localparam int               WATCHDOG_CYC = NUM_ENT * 2 * DATA_W * 16 + 500;
    localparam logic [31:0]      SEED         = 32'h235b_d997;

    typedef struct packed {
        spi_op_e           op;
        logic [CHAN_W-1:0] chan;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] resp;
        logic              reject;
        logic              together;
    } entry_s;

    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        logic [DATA_W-1:0] tx;
        logic [DATA_W-1:0] resp;
    } expect_s;

    // op, chan, tx data or divider, response, reject, next entry on next cycle
    localparam entry_s TABLE [NUM_ENT] = '{
        '{OP_XFER, 2'd0, 8'hA5, 8'h00, 1'b0, 1'b0},
        '{OP_XFER, 2'd1, 8'h3C, 8'h00, 1'b0, 1'b0},
        '{OP_XFER, 2'd2, 8'hF0, 8'h00, 1'b0, 1'b0},
        '{OP_CFG,  2'd1, 8'h03, 8'h00, 1'b0, 1'b0},
        '{OP_XFER, 2'd1, 8'h96, 8'h00, 1'b0, 1'b0},
        '{OP_CFG,  2'd1, 8'h01, 8'h00, 1'b0, 1'b0},
        '{OP_XFER, 2'd0, 8'h5A, 8'h00, 1'b0, 1'b1},
        '{OP_XFER, 2'd0, 8'h11, 8'h00, 1'b1, 1'b1},
        '{OP_CFG,  2'd0, 8'h07, 8'h00, 1'b1, 1'b0},
        '{OP_XFER, 2'd3, 8'h77, 8'h00, 1'b1, 1'b0},
        '{OP_CFG,  2'd3, 8'h02, 8'h00, 1'b1, 1'b0},
        '{OP_XFER, 2'd0, 8'hC3, 8'h00, 1'b0, 1'b1},
        '{OP_XFER, 2'd1, 8'h81, 8'h00, 1'b0, 1'b1},
        '{OP_XFER, 2'd2, 8'h7E, 8'h00, 1'b0, 1'b0}
    };

    logic                clk = 1'b0;
    logic                rst_n;
    spi_cmd_s            cmd;
    logic                cmd_valid;
    logic                cmd_reject;
    spi_result_s         result;
    logic                result_valid;
    logic [NUM_CHAN-1:0] busy;
    logic [NUM_CHAN-1:0] sclk;
    logic [NUM_CHAN-1:0] cs_n;
    logic [NUM_CHAN-1:0] mosi;
    logic [NUM_CHAN-1:0] miso;
    logic [DATA_W-1:0]   resp_byte [NUM_CHAN];
    logic [DATA_W-1:0]   cap_byte [NUM_CHAN];
    logic [DIV_W-1:0]    exp_div [NUM_CHAN];
    int                  phase_len [NUM_CHAN];
    logic [NUM_CHAN-1:0] sclk_prev;
    expect_s             exp_q [$];
    entry_s              tbl [NUM_ENT];
    logic                cur_reject;
    logic                reject_due;
    int                  checks;
    int                  errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    spi_multi_master #(
        .NUM_CHAN    (NUM_CHAN),
        .DEFAULT_DIV (DEFAULT_DIV)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_reject   (cmd_reject),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso)
    );

    // ------------------------------
    // SPI slave models, mode 0
    // ------------------------------
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_slave
        logic [DATA_W-1:0] out_sh = '0;
        logic [DATA_W-1:0] in_sh  = '0;
        logic              sclk_q = 1'b0;
        logic              cs_q   = 1'b1;

        always @(sclk[c] or cs_n[c]) begin
            if (!cs_n[c] && cs_q) begin
                out_sh = resp_byte[c];
                in_sh  = '0;
            end else if (sclk[c] && !sclk_q) begin
                in_sh = {in_sh[DATA_W-2:0], mosi[c]};
            end else if (!sclk[c] && sclk_q) begin
                out_sh = {out_sh[DATA_W-2:0], 1'b0};
            end
            sclk_q = sclk[c];
            cs_q   = cs_n[c];
        end

        assign miso[c]     = out_sh[DATA_W-1];
        assign cap_byte[c] = in_sh;
    end

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic note_fail(input string what);
        errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    // Drive one table entry and record what the DUT owes us
    task automatic issue(input entry_s e);
        cmd.op = e.op;
        if (e.op == OP_XFER) begin
            cmd.payload.xfer.chan    = e.chan;
            cmd.payload.xfer.tx_data = e.data;
            if (!e.reject) begin
                resp_byte[e.chan] = e.resp;
                exp_q.push_back(expect_s'{chan: e.chan, tx: e.data, resp: e.resp});
            end
        end else begin
            cmd.payload.cfg.chan = e.chan;
            cmd.payload.cfg.rsvd = '0;
            cmd.payload.cfg.div  = e.data[DIV_W-1:0];
            if (!e.reject) begin
                exp_div[e.chan] = e.data[DIV_W-1:0];
            end
        end
        cur_reject = e.reject;
        cmd_valid  = 1'b1;
    endtask

    // ------------------------------
    // Monitors, sampled mid-cycle
    // ------------------------------
    always @(negedge clk) begin
        expect_s e;
        if (rst_n) begin
            check_val("cmd_reject", int'(cmd_reject), int'(reject_due));
            if (result_valid) begin
                assert (exp_q.size() != 0) else note_fail("result_valid with nothing outstanding");
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    check_val("result.chan", int'(result.chan), int'(e.chan));
                    check_val("result.rx_data", int'(result.rx_data), int'(e.resp));
                    check_val("slave mosi byte", int'(cap_byte[e.chan]), int'(e.tx));
                end
            end
            // Each SCLK phase under cs_n lasts div+1 clocks
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (cs_n[c]) begin
                    phase_len[c] = 0;
                end else if (sclk[c] != sclk_prev[c] && phase_len[c] != 0) begin
                    check_val($sformatf("sclk[%0d] phase", c), phase_len[c],
                              int'(exp_div[c]) + 1);
                    phase_len[c] = 1;
                end else begin
                    phase_len[c]++;
                end
            end
        end
        reject_due = cmd_valid && cur_reject;
        sclk_prev  = sclk;
    end

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        cmd        = '0;
        cmd_valid  = 1'b0;
        cur_reject = 1'b0;
        reject_due = 1'b0;
        sclk_prev  = '0;
        checks     = 0;
        errors     = 0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            resp_byte[c] = '0;
            exp_div[c]   = DEFAULT_DIV;
            phase_len[c] = 0;
        end
        for (int i = 0; i < NUM_ENT; i++) begin
            tbl[i]      = TABLE[i];
            tbl[i].resp = DATA_W'($urandom);
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("cmd_reject", int'(cmd_reject), 0);
        check_val("result_valid", int'(result_valid), 0);
        check_val("busy", int'(busy), 0);
        check_val("sclk", int'(sclk), 0);
        check_val("mosi", int'(mosi), 0);
        check_val("cs_n", int'(cs_n), int'({NUM_CHAN{1'b1}}));

        for (int i = 0; i < NUM_ENT; i++) begin
            @(posedge clk);
            #1;
            issue(tbl[i]);
            if (!tbl[i].together) begin
                @(posedge clk);
                #1;
                cmd_valid = 1'b0;
                while (exp_q.size() != 0 || busy != '0) begin
                    @(negedge clk);
                end
            end
        end
        repeat (4) @(posedge clk);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized for the slowest divider on every entry
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        note_fail("watchdog expired before the table finished");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: flist.f
hw/spi_pkg.sv
hw/spi_cmd_dispatch.sv
hw/spi_channel_engine.sv
hw/spi_result_collect.sv
hw/spi_multi_master.sv
testbench/spi_multi_master_properties.sv
testbench/tb_spi_multi_master.sv

// File: Makefile
# Verilator build and run for the SPI multi-master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_multi_master
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All checks passed

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
